//--- common/stereo_pkg.sv
`default_nettype none

package stereo_pkg;

	// ----------------------------------------------------------
	// image geometry
	// ----------------------------------------------------------
	localparam int IMG_W      = 16;             // pixels per line
	localparam int IMG_H      = 8;              // lines per frame
	localparam int IMG_PIXELS = IMG_W * IMG_H;  // 128 per image
	localparam int PIX_W      = 8;              // grey level width

	// ----------------------------------------------------------
	// matching window and search range
	// ----------------------------------------------------------
	localparam int WIN_RADIUS = 1;                                      // 3x3 window
	localparam int WIN_TAPS   = (2 * WIN_RADIUS + 1) * (2 * WIN_RADIUS + 1);
	localparam int MAX_DISP   = 7;                                      // offsets 0..7
	localparam int DISP_SCALE = 255 / MAX_DISP;                         // 36 grey per step
	localparam int OFS_W      = $clog2(MAX_DISP + 1);                   // offset width
	localparam int SSD_W      = 20;                                     // 9 * 255^2 fits

	// frame timing
	localparam int VSYNC_CYCLES = 8;  // vsync phase after load
	localparam int HSYNC_CYCLES = 4;  // hsync phase before each line

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef logic [PIX_W-1:0]              pix_t;
	typedef logic [OFS_W-1:0]              ofs_t;
	typedef logic [$clog2(IMG_H)-1:0]      row_t;
	typedef logic [$clog2(IMG_W)-1:0]      col_t;
	typedef logic [$clog2(IMG_PIXELS)-1:0] addr_t;  // frame buffer address
	typedef logic [SSD_W-1:0]              ssd_t;

	typedef struct packed {
		pix_t left;   // left image sample
		pix_t right;  // right image sample, same position
	} pixel_pair_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} pix_pos_t;

	typedef struct packed {
		pix_pos_t pos;  // left pixel the result belongs to
		pix_t     level; // best offset scaled to grey
	} disp_out_t;

endpackage

`default_nettype wire

//--- frame_store/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

// left and right frame buffers, filled from the pixel pair stream
module frame_store (
	input  wire                            HCLK,
	input  wire                            HRESETn,
	// load side
	input  wire stereo_pkg::pixel_pair_t   pix_in,
	input  wire                            pix_valid,
	input  wire                            load_en,
	output logic                           pix_ready,
	output logic                           load_done,
	// read side, one registered read per image
	input  wire                            rd_en,
	input  wire stereo_pkg::addr_t         rd_addr_l,
	input  wire stereo_pkg::addr_t         rd_addr_r,
	output stereo_pkg::pix_t               rd_pix_l,
	output stereo_pkg::pix_t               rd_pix_r
);

	stereo_pkg::pix_t  mem_l [stereo_pkg::IMG_PIXELS];  // left image
	stereo_pkg::pix_t  mem_r [stereo_pkg::IMG_PIXELS];  // right image
	stereo_pkg::addr_t wr_ptr;                          // raster write position
	logic              wr_en;
	logic              wr_last;

	assign pix_ready = load_en;              // only accept during load phase
	assign wr_en     = pix_valid & load_en;  // pair transfers this clock
	assign wr_last   = wr_ptr == stereo_pkg::addr_t'(stereo_pkg::IMG_PIXELS - 1);
	assign load_done = wr_en & wr_last;      // last pair of the frame written now

	// write pointer, wraps so the next frame starts at 0
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			if (wr_last)
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// memory write and registered read
	// ----------------------------------------------------------
	always_ff @(posedge HCLK) begin
		if (wr_en) begin
			mem_l[wr_ptr] <= pix_in.left;
			mem_r[wr_ptr] <= pix_in.right;
		end
		if (rd_en) begin
			rd_pix_l <= mem_l[rd_addr_l];  // data valid next cycle
			rd_pix_r <= mem_r[rd_addr_r];
		end
	end

endmodule

`default_nettype wire

//--- matcher/ssd_window.sv
`timescale 1ns/1ps
`default_nettype none

// sum of squared differences over the window, one tap per clock
module ssd_window (
	input  wire                         HCLK,
	input  wire                         HRESETn,
	input  wire                         win_start,   // one cycle pulse
	input  wire stereo_pkg::pix_pos_t   win_pos,     // centre pixel, left image
	input  wire stereo_pkg::ofs_t       win_offset,  // right image shift
	output logic                        win_done,
	output stereo_pkg::ssd_t            win_ssd,
	// frame store read port
	output logic                        rd_en,
	output stereo_pkg::addr_t           rd_addr_l,
	output stereo_pkg::addr_t           rd_addr_r,
	input  wire stereo_pkg::pix_t       rd_pix_l,
	input  wire stereo_pkg::pix_t       rd_pix_r
);

	logic                  busy;            // taps still being issued
	logic [1:0]            tx, ty;          // tap column / row inside window
	logic                  last_tap;
	stereo_pkg::pix_pos_t  pos_q;
	stereo_pkg::ofs_t      ofs_q;
	logic signed [5:0]     row_s;           // tap row, may fall outside
	logic signed [5:0]     col_ls, col_rs;  // tap column left / right
	logic                  in_row, in_l, in_r;
	logic                  vld_d, last_d;   // read data returning this cycle
	logic                  in_l_d, in_r_d;  // range flags aligned to read data
	stereo_pkg::pix_t      pl, pr, ad;
	logic [2*stereo_pkg::PIX_W-1:0] sq;
	stereo_pkg::ssd_t      acc;

	// ----------------------------------------------------------
	// tap coordinates and range check
	// ----------------------------------------------------------
	assign row_s  = 6'(pos_q.row) + 6'(ty) - 6'(stereo_pkg::WIN_RADIUS);
	assign col_ls = 6'(pos_q.col) + 6'(tx) - 6'(stereo_pkg::WIN_RADIUS);
	assign col_rs = col_ls - 6'(ofs_q);  // right image looks further left

	assign in_row = (row_s >= 0) && (row_s < stereo_pkg::IMG_H);
	assign in_l   = in_row && (col_ls >= 0) && (col_ls < stereo_pkg::IMG_W);
	assign in_r   = in_row && (col_rs >= 0) && (col_rs < stereo_pkg::IMG_W);

	// outside taps give junk addresses, masked on return
	assign rd_en     = busy;
	assign rd_addr_l = stereo_pkg::addr_t'(row_s * stereo_pkg::IMG_W + col_ls);
	assign rd_addr_r = stereo_pkg::addr_t'(row_s * stereo_pkg::IMG_W + col_rs);

	assign last_tap = (tx == 2'(2 * stereo_pkg::WIN_RADIUS)) &&
	                  (ty == 2'(2 * stereo_pkg::WIN_RADIUS));

	// tap walk, row by row
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			busy   <= 1'b0;
			tx     <= '0;
			ty     <= '0;
			vld_d  <= 1'b0;
			last_d <= 1'b0;
		end else begin
			vld_d  <= busy;             // read issued now, data next cycle
			last_d <= busy & last_tap;
			if (win_start) begin
				busy <= 1'b1;
				tx   <= '0;
				ty   <= '0;
			end else if (busy) begin
				if (last_tap)
					busy <= 1'b0;
				if (tx == 2'(2 * stereo_pkg::WIN_RADIUS)) begin
					tx <= '0;
					ty <= ty + 1'b1;  // next window row
				end else begin
					tx <= tx + 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// squared difference and accumulate
	// ----------------------------------------------------------
	assign pl  = in_l_d ? rd_pix_l : '0;  // outside counts as 0
	assign pr  = in_r_d ? rd_pix_r : '0;
	assign ad  = (pl > pr) ? pl - pr : pr - pl;
	assign sq  = ad * ad;

	assign win_done = vld_d & last_d;                   // last tap returning
	assign win_ssd  = acc + stereo_pkg::ssd_t'(sq);     // includes last tap

	always_ff @(posedge HCLK) begin
		if (win_start) begin
			pos_q <= win_pos;
			ofs_q <= win_offset;
		end
		in_l_d <= in_l;
		in_r_d <= in_r;
		if (win_start)
			acc <= '0;
		else if (vld_d)
			acc <= acc + stereo_pkg::ssd_t'(sq);
	end

endmodule

`default_nettype wire

//--- matcher/disparity_search.sv
`timescale 1ns/1ps
`default_nettype none

// runs the window over every offset and keeps the smallest ssd
module disparity_search (
	input  wire                         HCLK,
	input  wire                         HRESETn,
	// request from the sequencer
	input  wire stereo_pkg::pix_pos_t   req_pos,
	input  wire                         req_valid,
	output logic                        req_ready,
	// window engine
	output logic                        win_start,
	output stereo_pkg::pix_pos_t        win_pos,
	output stereo_pkg::ofs_t            win_offset,
	input  wire                         win_done,
	input  wire stereo_pkg::ssd_t       win_ssd,
	// result stream
	output stereo_pkg::disp_out_t       disp,
	output logic                        disp_valid,
	input  wire                         disp_ready,
	output logic                        resp_accepted
);

	typedef enum logic [1:0] {
		S_IDLE,   // waiting for a pixel
		S_START,  // launch window for current offset
		S_WAIT,   // window running, compare on done
		S_OUT     // result held until accepted
	} state_t;

	state_t               state;
	stereo_pkg::ofs_t     ofs;        // offset under test
	stereo_pkg::ofs_t     best_ofs;
	stereo_pkg::ofs_t     next_best;
	stereo_pkg::ssd_t     best_ssd;
	stereo_pkg::pix_pos_t pos_q;
	logic                 better;
	logic                 last_ofs;
	stereo_pkg::pix_t     level;

	assign req_ready     = state == S_IDLE;
	assign win_start     = state == S_START;
	assign win_pos       = pos_q;
	assign win_offset    = ofs;
	assign disp_valid    = state == S_OUT;
	assign resp_accepted = disp_valid & disp_ready;

	// strict compare, ties keep the lower offset
	assign better    = win_ssd < best_ssd;
	assign next_best = better ? ofs : best_ofs;
	assign last_ofs  = ofs == stereo_pkg::ofs_t'(stereo_pkg::MAX_DISP);
	assign level     = stereo_pkg::pix_t'(next_best * stereo_pkg::DISP_SCALE);

	// ----------------------------------------------------------
	// search control
	// ----------------------------------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state <= S_IDLE;
			ofs   <= '0;
		end else begin
			case (state)
				S_IDLE: if (req_valid) begin
					ofs   <= '0;
					state <= S_START;
				end
				S_START: state <= S_WAIT;
				S_WAIT: if (win_done) begin
					if (last_ofs) begin
						state <= S_OUT;  // disp loaded on this edge
					end else begin
						ofs   <= ofs + 1'b1;
						state <= S_START;
					end
				end
				S_OUT: if (disp_ready)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// best so far and the result register
	always_ff @(posedge HCLK) begin
		if (state == S_IDLE && req_valid) begin
			pos_q    <= req_pos;
			best_ssd <= '1;  // above any real sum, offset 0 always wins first
		end
		if (state == S_WAIT && win_done) begin
			if (better) begin
				best_ssd <= win_ssd;
				best_ofs <= ofs;
			end
			if (last_ofs) begin
				disp.pos   <= pos_q;
				disp.level <= level;  // held through back-pressure
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// frame phases: load, vsync, per line hsync, per pixel issue/wait
module frame_sequencer (
	input  wire                   HCLK,
	input  wire                   HRESETn,
	output logic                  load_en,
	input  wire                   load_done,
	output logic                  vsync,
	output logic                  hsync,
	output stereo_pkg::pix_pos_t  req_pos,
	output logic                  req_valid,
	input  wire                   req_ready,
	input  wire                   resp_accepted,
	output logic                  frame_done
);

	typedef enum logic [2:0] {
		ST_IDLE,   // out of reset only
		ST_LOAD,   // frame buffers filling
		ST_VSYNC,
		ST_HSYNC,
		ST_ISSUE,  // request out to search
		ST_WAIT,   // pixel in flight
		ST_DONE    // one cycle frame done
	} state_t;

	state_t               state;
	logic [3:0]           phase_cnt;  // vsync / hsync length
	stereo_pkg::pix_pos_t pos;        // current pixel
	logic                 last_col, last_row;

	assign load_en    = state == ST_LOAD;
	assign vsync      = state == ST_VSYNC;
	assign hsync      = state == ST_HSYNC;
	assign req_valid  = state == ST_ISSUE;
	assign frame_done = state == ST_DONE;
	assign req_pos    = pos;

	assign last_col = pos.col == stereo_pkg::col_t'(stereo_pkg::IMG_W - 1);
	assign last_row = pos.row == stereo_pkg::row_t'(stereo_pkg::IMG_H - 1);

	// ----------------------------------------------------------
	// frame FSM with row / col counters
	// ----------------------------------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state     <= ST_IDLE;
			phase_cnt <= '0;
			pos       <= '0;
		end else begin
			case (state)
				ST_IDLE: state <= ST_LOAD;  // straight into load after reset
				ST_LOAD: if (load_done) begin
					phase_cnt <= '0;
					state     <= ST_VSYNC;
				end
				ST_VSYNC: begin
					if (phase_cnt == 4'(stereo_pkg::VSYNC_CYCLES - 1)) begin
						phase_cnt <= '0;
						state     <= ST_HSYNC;  // first line follows directly
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				ST_HSYNC: begin
					if (phase_cnt == 4'(stereo_pkg::HSYNC_CYCLES - 1)) begin
						phase_cnt <= '0;
						state     <= ST_ISSUE;
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				ST_ISSUE: if (req_ready)
					state <= ST_WAIT;
				ST_WAIT: if (resp_accepted) begin
					if (last_col) begin
						pos.col <= '0;
						if (last_row) begin
							pos.row <= '0;
							state   <= ST_DONE;
						end else begin
							pos.row <= pos.row + 1'b1;
							state   <= ST_HSYNC;  // gap before next line
						end
					end else begin
						pos.col <= pos.col + 1'b1;
						state   <= ST_ISSUE;
					end
				end
				ST_DONE: state <= ST_LOAD;  // next frame
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/stereo_disparity_top.sv
`timescale 1ns/1ps
`default_nettype none

// stereo block matching, one disparity per left pixel
module stereo_disparity_top (
	input  wire                            HCLK,
	input  wire                            HRESETn,
	// image pair stream in
	input  wire stereo_pkg::pixel_pair_t   pix_in,
	input  wire                            pix_valid,
	output logic                           pix_ready,
	// disparity stream out
	output stereo_pkg::disp_out_t          disp,
	output logic                           disp_valid,
	input  wire                            disp_ready,
	// frame status
	output logic                           vsync,
	output logic                           hsync,
	output logic                           frame_done
);

	// sequencer <-> frame store / search
	logic                 load_en, load_done;
	stereo_pkg::pix_pos_t req_pos;
	logic                 req_valid, req_ready;
	logic                 resp_accepted;

	// search <-> window
	logic                 win_start, win_done;
	stereo_pkg::pix_pos_t win_pos;
	stereo_pkg::ofs_t     win_offset;
	stereo_pkg::ssd_t     win_ssd;

	// window <-> frame store
	logic                 rd_en;
	stereo_pkg::addr_t    rd_addr_l, rd_addr_r;
	stereo_pkg::pix_t     rd_pix_l, rd_pix_r;

	frame_sequencer i_frame_sequencer (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.load_en       (load_en),
		.load_done     (load_done),
		.vsync         (vsync),
		.hsync         (hsync),
		.req_pos       (req_pos),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.resp_accepted (resp_accepted),
		.frame_done    (frame_done)
	);

	frame_store i_frame_store (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.pix_in    (pix_in),
		.pix_valid (pix_valid),
		.load_en   (load_en),
		.pix_ready (pix_ready),
		.load_done (load_done),
		.rd_en     (rd_en),
		.rd_addr_l (rd_addr_l),
		.rd_addr_r (rd_addr_r),
		.rd_pix_l  (rd_pix_l),
		.rd_pix_r  (rd_pix_r)
	);

	disparity_search i_disparity_search (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.req_pos       (req_pos),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.win_start     (win_start),
		.win_pos       (win_pos),
		.win_offset    (win_offset),
		.win_done      (win_done),
		.win_ssd       (win_ssd),
		.disp          (disp),
		.disp_valid    (disp_valid),
		.disp_ready    (disp_ready),
		.resp_accepted (resp_accepted)
	);

	ssd_window i_ssd_window (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.win_start  (win_start),
		.win_pos    (win_pos),
		.win_offset (win_offset),
		.win_done   (win_done),
		.win_ssd    (win_ssd),
		.rd_en      (rd_en),
		.rd_addr_l  (rd_addr_l),
		.rd_addr_r  (rd_addr_r),
		.rd_pix_l   (rd_pix_l),
		.rd_pix_r   (rd_pix_r)
	);

endmodule

`default_nettype wire

//--- verif/tb_stereo_disparity.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stereo_disparity;

	localparam int FRAMES         = 3;
	localparam int TIMEOUT_CYCLES = 2 * FRAMES * (stereo_pkg::IMG_PIXELS * 100 + 200);
	localparam int W              = stereo_pkg::IMG_W;
	localparam int R              = stereo_pkg::WIN_RADIUS;

	logic                    HCLK;
	logic                    HRESETn;
	stereo_pkg::pixel_pair_t pix_in;
	logic                    pix_valid;
	logic                    pix_ready;
	stereo_pkg::disp_out_t   disp;
	logic                    disp_valid;
	logic                    disp_ready;
	logic                    vsync, hsync, frame_done;

	int seed;
	int ready_seed;   // separate stream for back-pressure
	int errors, checks;
	int cycle_cnt;
	int frames_seen;
	bit mon_en;       // monitor runs once reset is over

	stereo_pkg::pix_t img_l [stereo_pkg::IMG_PIXELS];
	stereo_pkg::pix_t img_r [stereo_pkg::IMG_PIXELS];
	int               exp_level [stereo_pkg::IMG_PIXELS];  // model result per pixel

	// monitor state
	int                    pairs_in, vs_len, hs_len, hs_count, res_count;
	bit                    in_frame;
	logic                  prev_vsync, prev_hsync, prev_valid, prev_ready, prev_fd;
	stereo_pkg::disp_out_t prev_disp;

	stereo_disparity_top i_stereo_disparity_top (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.pix_in     (pix_in),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.disp       (disp),
		.disp_valid (disp_valid),
		.disp_ready (disp_ready),
		.vsync      (vsync),
		.hsync      (hsync),
		.frame_done (frame_done)
	);

	initial HCLK = 1'b0;
	always #2 HCLK = ~HCLK;  // 4 ns period

	// random back-pressure with about one low cycle in four
	always @(posedge HCLK) begin
		#1 disp_ready = ($random(ready_seed) & 3) != 0;
	end

	// ----------------------------------------------------------
	// check helpers
	// ----------------------------------------------------------
	task automatic compare_value(input string name, input logic [31:0] got,
	                             input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	function automatic bit on_image(input int r, input int c);
		return (r >= 0) && (r < stereo_pkg::IMG_H) && (c >= 0) && (c < W);
	endfunction

	// ----------------------------------------------------------
	// stimulus and reference model
	// ----------------------------------------------------------
	// right image is the left one moved by shift plus small noise
	task automatic make_frame(input int shift);
		int i, r, c;
		int base, v;
		for (i = 0; i < stereo_pkg::IMG_PIXELS; i++)
			img_l[i] = stereo_pkg::pix_t'($random(seed));
		for (r = 0; r < stereo_pkg::IMG_H; r++) begin
			for (c = 0; c < W; c++) begin
				if (c + shift < W)
					base = img_l[r * W + c + shift];
				else
					base = $random(seed) & 255;  // no source pixel so fresh random
				v = base + $random(seed) % 4;    // noise -3..3
				if (v < 0)
					v = 0;
				else if (v > 255)
					v = 255;
				img_r[r * W + c] = stereo_pkg::pix_t'(v);
			end
		end
	endtask

	// ssd per offset with zero outside the image and the lowest offset winning ties
	task automatic model_disparity();
		int r, c, d, dy, dx;
		int pl, pr, ssd, best_ssd, best;
		for (r = 0; r < stereo_pkg::IMG_H; r++) begin
			for (c = 0; c < W; c++) begin
				best_ssd = 32'h7fff_ffff;
				best     = 0;
				for (d = 0; d <= stereo_pkg::MAX_DISP; d++) begin
					ssd = 0;
					for (dy = -R; dy <= R; dy++) begin
						for (dx = -R; dx <= R; dx++) begin
							pl  = on_image(r + dy, c + dx) ? img_l[(r + dy) * W + c + dx] : 0;
							pr  = on_image(r + dy, c + dx - d) ?
							      img_r[(r + dy) * W + c + dx - d] : 0;
							ssd = ssd + (pl - pr) * (pl - pr);
						end
					end
					if (ssd < best_ssd) begin
						best_ssd = ssd;
						best     = d;
					end
				end
				exp_level[r * W + c] = best * stereo_pkg::DISP_SCALE;
			end
		end
	endtask

	// raster stream with random gaps in pix_valid
	task automatic stream_frame();
		int idx;
		bit taken;
		idx = 0;
		@(posedge HCLK);
		#1;
		while (idx < stereo_pkg::IMG_PIXELS) begin
			pix_valid    = ($random(seed) & 3) != 0;
			pix_in.left  = img_l[idx];
			pix_in.right = img_r[idx];
			@(negedge HCLK);
			taken = pix_valid && pix_ready;  // handshake seen before the edge
			@(posedge HCLK);
			#1;
			if (taken)
				idx++;
		end
		pix_valid = 1'b0;
	endtask

	task automatic wait_frame_done();
		@(negedge HCLK);
		while (!frame_done)
			@(negedge HCLK);
		@(negedge HCLK);  // monitor sees the reload after frame_done here
		@(posedge HCLK);
	endtask

	// ----------------------------------------------------------
	// monitor samples mid-cycle where everything is settled
	// ----------------------------------------------------------
	always @(negedge HCLK) begin
		stereo_pkg::pix_pos_t exp_pos;
		if (mon_en) begin
			if (pix_valid && pix_ready)
				pairs_in++;
			if (vsync && !prev_vsync) begin  // load over so the frame starts
				compare_value("pairs before vsync", pairs_in, stereo_pkg::IMG_PIXELS);
				pairs_in = 0;
				vs_len   = 0;
				in_frame = 1'b1;
			end
			if (vsync)
				vs_len++;
			if (!vsync && prev_vsync)
				compare_value("vsync length", vs_len, stereo_pkg::VSYNC_CYCLES);
			if (in_frame)
				require(!pix_ready, "pix_ready high while the frame is being processed");

			if (hsync && !prev_hsync) begin
				hs_count++;
				hs_len = 0;
			end
			if (hsync) begin
				hs_len++;
				require(!disp_valid, "disp_valid high during hsync");
			end
			if (!hsync && prev_hsync)
				compare_value("hsync length", hs_len, stereo_pkg::HSYNC_CYCLES);

			// result not taken last cycle must still be there unchanged
			if (prev_valid && !prev_ready) begin
				require(disp_valid, "disp_valid dropped before the result was accepted");
				compare_value("disp", disp, prev_disp);
			end

			if (disp_valid && disp_ready) begin
				if (res_count < stereo_pkg::IMG_PIXELS) begin
					exp_pos.row = stereo_pkg::row_t'(res_count / W);
					exp_pos.col = stereo_pkg::col_t'(res_count % W);
					compare_value("disp.pos", disp.pos, exp_pos);
					compare_value("disp.level", disp.level, exp_level[res_count]);
				end else begin
					require(1'b0, "result beyond the last pixel of the frame");
				end
				res_count++;
			end

			if (prev_fd)
				require(pix_ready, "loading did not resume after frame_done");
			if (frame_done) begin
				require(!prev_fd, "frame_done longer than one cycle");
				compare_value("hsync pulses", hs_count, stereo_pkg::IMG_H);
				compare_value("results per frame", res_count, stereo_pkg::IMG_PIXELS);
				frames_seen++;
				hs_count  = 0;
				res_count = 0;
				in_frame  = 1'b0;
			end
		end
		prev_vsync = vsync;
		prev_hsync = hsync;
		prev_valid = disp_valid;
		prev_ready = disp_ready;
		prev_fd    = frame_done;
		prev_disp  = disp;
	end

	// watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge HCLK);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, only %0d frames finished", cycle_cnt, frames_seen);
		$display("RESULT: FAIL");
		$finish;
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin
		int fail_before;
		int shift;
		int f;
		seed        = 32'h4bd8_9a07;
		ready_seed  = seed ^ 32'h0000_ffff;
		HRESETn     = 1'b0;
		pix_in      = '0;
		pix_valid   = 1'b0;
		disp_ready  = 1'b0;
		errors      = 0;
		checks      = 0;
		frames_seen = 0;
		mon_en      = 1'b0;
		pairs_in    = 0;
		vs_len      = 0;
		hs_len      = 0;
		hs_count    = 0;
		res_count   = 0;
		in_frame    = 1'b0;

		// outputs quiet in reset and just after it
		repeat (10) begin
			@(negedge HCLK);
			compare_value("vsync", vsync, 0);
			compare_value("hsync", hsync, 0);
			compare_value("disp_valid", disp_valid, 0);
			compare_value("frame_done", frame_done, 0);
		end
		@(posedge HCLK);
		#1 HRESETn = 1'b1;
		@(negedge HCLK);
		compare_value("vsync", vsync, 0);
		compare_value("hsync", hsync, 0);
		compare_value("disp_valid", disp_valid, 0);
		compare_value("frame_done", frame_done, 0);
		mon_en = 1'b1;
		$display("test reset: %0d errors", errors);

		for (f = 0; f < FRAMES; f++) begin
			fail_before = errors;
			shift       = $unsigned($random(seed)) % (stereo_pkg::MAX_DISP + 1);
			make_frame(shift);
			model_disparity();
			stream_frame();
			wait_frame_done();
			$display("test frame %0d, shift %0d: %0d errors", f, shift, errors - fail_before);
		end

		compare_value("frame_done count", frames_seen, FRAMES);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
common/stereo_pkg.sv
frame_store/frame_store.sv
matcher/ssd_window.sv
matcher/disparity_search.sv
hdl/frame_sequencer.sv
hdl/stereo_disparity_top.sv
verif/tb_stereo_disparity.sv
